//--- icache_cfg.svh
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// fetch address, block aligned
`define ICACHE_ADDR_SIZE 16

// byte offset inside one block
`define ICACHE_OFFSET_SIZE 3

// set index and remaining tag bits
`define ICACHE_INDEX_SIZE 4
`define ICACHE_TAG_SIZE 9

// geometry
`define ICACHE_SETS 16
`define ICACHE_WAYS 2
`define ICACHE_BLOCK_SIZE 64

// memory transaction tag, zero means none
`define MEM_TAG_SIZE 4

// request to data return, in cycles
`define MEM_LATENCY 6

`endif

//--- icache_pkg.sv
`include "icache_cfg.svh"

package icache_pkg;

	// block aligned program counter
	typedef logic [`ICACHE_ADDR_SIZE-1:0] pc_t;

	typedef logic [`ICACHE_INDEX_SIZE-1:0] index_t;

	typedef logic [`ICACHE_TAG_SIZE-1:0] tag_t;

	// one instruction block, the unit of fetch
	typedef logic [`ICACHE_BLOCK_SIZE-1:0] block_t;

	// one lookup into the tag array
	typedef struct packed
	{
		logic en;
		index_t index;
		tag_t tag;
	} lookup_t;

	// subsystem output, a single cycle strobe
	typedef struct packed
	{
		logic valid;
		pc_t pc;
		block_t block;
	} fetch_out_t;

	typedef enum logic [1:0]
	{
		LOOKUP,
		WAIT_FILL,
		REDIRECT
	} ctrl_state_t;

endpackage

//--- mem_bus_pkg.sv
`include "icache_cfg.svh"

package mem_bus_pkg;

	// transaction tag, zero is reserved for idle
	typedef logic [`MEM_TAG_SIZE-1:0] mem_tag_t;

	// line address with a zero byte offset
	typedef logic [`ICACHE_ADDR_SIZE-1:0] mem_addr_t;

	typedef logic [`ICACHE_BLOCK_SIZE-1:0] mem_data_t;

	typedef struct packed
	{
		logic valid;
		mem_addr_t addr;
	} mem_req_t;

	// data return, tag of zero when nothing comes back
	typedef struct packed
	{
		mem_tag_t tag;
		mem_data_t block;
	} mem_resp_t;

endpackage

//--- icache_ctrl.sv
`include "icache_cfg.svh"

module icache_ctrl (
	input logic clock,
	input logic reset,
	input logic redirect_valid,
	input icache_pkg::pc_t redirect_pc,
	input logic demand_hit,
	input logic demand_miss,
	input logic pref_miss,
	input logic cache_full,
	input logic fill_done,
	output icache_pkg::lookup_t demand,
	output icache_pkg::lookup_t prefetch,
	output logic do_lookup,
	output icache_pkg::pc_t fetch_pc,
	output logic fetch_fire
);

	// bytes per block
	localparam icache_pkg::pc_t STEP = icache_pkg::pc_t'(1) << `ICACHE_OFFSET_SIZE;

	icache_pkg::ctrl_state_t state;
	icache_pkg::pc_t pc;
	icache_pkg::pc_t pref_ptr;
	icache_pkg::pc_t target;

	function automatic icache_pkg::lookup_t make_lookup(input logic en, input icache_pkg::pc_t addr);
		icache_pkg::lookup_t l;
		l.en = en;
		l.index = addr[`ICACHE_OFFSET_SIZE +: `ICACHE_INDEX_SIZE];
		l.tag = addr[`ICACHE_ADDR_SIZE-1 -: `ICACHE_TAG_SIZE];
		return l;
	endfunction

	// no lookup in the redirect cycle, the line would be dropped anyway
	assign do_lookup = (state == icache_pkg::LOOKUP) && !redirect_valid;

	assign demand = make_lookup(do_lookup, pc);
	assign prefetch = make_lookup(do_lookup, pref_ptr);

	assign fetch_pc = pc;
	assign fetch_fire = (do_lookup && demand_hit) || fill_done;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= icache_pkg::LOOKUP;
			pc <= '0;
			pref_ptr <= STEP;
			target <= '0;
		end
		else if (redirect_valid)
		begin
			target <= redirect_pc;
			state <= icache_pkg::REDIRECT;
		end
		else
		begin
			case (state)
				icache_pkg::LOOKUP:
				begin
					if (demand_hit)
					begin
						pc <= pc + STEP;
						pref_ptr <= pref_ptr + STEP;
					end
					else
					begin
						if (demand_miss && !cache_full)
						begin
							state <= icache_pkg::WAIT_FILL;
						end
						// prefetch line already covered, run one more line ahead
						if (!pref_miss && (pref_ptr - pc) == STEP)
						begin
							pref_ptr <= pref_ptr + STEP;
						end
					end
				end
				icache_pkg::WAIT_FILL:
				begin
					if (fill_done)
					begin
						pc <= pc + STEP;
						state <= icache_pkg::LOOKUP;
						// keep the prefetch pointer ahead of the new pc
						if (pref_ptr == pc + STEP)
						begin
							pref_ptr <= pref_ptr + STEP;
						end
					end
				end
				icache_pkg::REDIRECT:
				begin
					pc <= target;
					pref_ptr <= target + STEP;
					state <= icache_pkg::LOOKUP;
				end
				default:
				begin
					state <= icache_pkg::LOOKUP;
				end
			endcase
		end
	end

	// the cache only forwards a line the controller is waiting for
	a_fill_in_wait: assert property (@(posedge clock) disable iff (reset)
		fill_done |-> state == icache_pkg::WAIT_FILL);

endmodule

//--- icache_mem.sv
`include "icache_cfg.svh"

module icache_mem (
	input logic clock,
	input logic reset,
	input icache_pkg::lookup_t demand,
	input icache_pkg::lookup_t prefetch,
	input logic do_lookup,
	input logic cancel,
	input mem_bus_pkg::mem_tag_t mem_response,
	input mem_bus_pkg::mem_resp_t mem_resp,
	output logic demand_hit,
	output logic demand_miss,
	output logic pref_miss,
	output logic cache_full,
	output logic fill_done,
	output icache_pkg::block_t read_data,
	output mem_bus_pkg::mem_req_t mem_req
);

	icache_pkg::block_t data_q [`ICACHE_SETS][`ICACHE_WAYS];
	icache_pkg::tag_t tag_q [`ICACHE_SETS][`ICACHE_WAYS];
	logic [`ICACHE_WAYS-1:0] valid_q [`ICACHE_SETS];
	mem_bus_pkg::mem_tag_t outst_q [`ICACHE_SETS][`ICACHE_WAYS];
	// per set, the way to evict next
	logic [`ICACHE_SETS-1:0] lru_q;

	// tag of the line the controller is waiting on
	logic await_valid;
	mem_bus_pkg::mem_tag_t await_tag;

	logic [`ICACHE_WAYS-1:0] d_hit_way;
	logic [`ICACHE_WAYS-1:0] d_pend_way;
	logic [`ICACHE_WAYS-1:0] p_hit_way;
	logic [`ICACHE_WAYS-1:0] p_pend_way;
	logic d_hit_w;
	logic d_pend_w;
	logic d_victim;
	logic p_victim;
	logic d_lookup;
	logic p_lookup;
	logic d_fwd;
	logic d_alloc;
	logic p_alloc;
	logic resp_live;
	logic resp_known;
	mem_bus_pkg::mem_tag_t d_pend_tag;
	logic [`ICACHE_SETS-1:0][`ICACHE_WAYS-1:0] resp_hit;

	function automatic mem_bus_pkg::mem_addr_t line_addr(input icache_pkg::lookup_t l);
		return {l.tag, l.index, {`ICACHE_OFFSET_SIZE{1'b0}}};
	endfunction

	always_comb
	begin
		d_lookup = do_lookup && demand.en;
		p_lookup = do_lookup && prefetch.en;
		for (int w = 0; w < `ICACHE_WAYS; w++)
		begin
			d_hit_way[w] = valid_q[demand.index][w] && tag_q[demand.index][w] == demand.tag;
			d_pend_way[w] = outst_q[demand.index][w] != '0
				&& tag_q[demand.index][w] == demand.tag;
			p_hit_way[w] = valid_q[prefetch.index][w] && tag_q[prefetch.index][w] == prefetch.tag;
			p_pend_way[w] = outst_q[prefetch.index][w] != '0
				&& tag_q[prefetch.index][w] == prefetch.tag;
		end
		d_hit_w = d_hit_way[1];
		d_pend_w = d_pend_way[1];
		d_pend_tag = outst_q[demand.index][d_pend_w];
		resp_live = mem_resp.tag != '0;

		// line in flight returns right now, pass it through
		d_fwd = d_lookup && |d_pend_way && resp_live && d_pend_tag == mem_resp.tag;
		demand_hit = d_lookup && (|d_hit_way || d_fwd);
		demand_miss = d_lookup && !demand_hit;

		d_victim = lru_q[demand.index];
		cache_full = demand_miss && !(|d_pend_way) && outst_q[demand.index][d_victim] != '0;
		d_alloc = demand_miss && !(|d_pend_way) && !cache_full;

		// prefetch only rides on a demand hit, into another set
		pref_miss = p_lookup && !(|p_hit_way) && !(|p_pend_way);
		p_victim = lru_q[prefetch.index];
		p_alloc = pref_miss && demand_hit && prefetch.index != demand.index
			&& outst_q[prefetch.index][p_victim] == '0;

		for (int s = 0; s < `ICACHE_SETS; s++)
		begin
			for (int w = 0; w < `ICACHE_WAYS; w++)
			begin
				resp_hit[s][w] = resp_live && outst_q[s][w] == mem_resp.tag;
			end
		end
		resp_known = |resp_hit;
	end

	assign fill_done = await_valid && !cancel && resp_live && mem_resp.tag == await_tag;

	assign read_data = (fill_done || d_fwd) ? mem_resp.block : data_q[demand.index][d_hit_w];

	assign mem_req.valid = d_alloc || p_alloc;
	assign mem_req.addr = d_alloc ? line_addr(demand) : line_addr(prefetch);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int s = 0; s < `ICACHE_SETS; s++)
			begin
				valid_q[s] <= '0;
				for (int w = 0; w < `ICACHE_WAYS; w++)
				begin
					outst_q[s][w] <= '0;
				end
			end
			lru_q <= '0;
			await_valid <= 1'b0;
			await_tag <= '0;
		end
		else
		begin
			// returning line becomes valid, its way is free again
			for (int s = 0; s < `ICACHE_SETS; s++)
			begin
				for (int w = 0; w < `ICACHE_WAYS; w++)
				begin
					if (resp_hit[s][w])
					begin
						valid_q[s][w] <= 1'b1;
						outst_q[s][w] <= '0;
					end
				end
			end

			if (d_alloc)
			begin
				valid_q[demand.index][d_victim] <= 1'b0;
				outst_q[demand.index][d_victim] <= mem_response;
				lru_q[demand.index] <= !d_victim;
			end
			else if (demand_hit)
			begin
				lru_q[demand.index] <= d_fwd ? !d_pend_w : !d_hit_w;
			end

			if (p_alloc)
			begin
				valid_q[prefetch.index][p_victim] <= 1'b0;
				outst_q[prefetch.index][p_victim] <= mem_response;
				lru_q[prefetch.index] <= !p_victim;
			end

			if (cancel)
			begin
				await_valid <= 1'b0;
			end
			else if (demand_miss && !cache_full)
			begin
				await_valid <= 1'b1;
				// a line already in flight is awaited under its own tag
				await_tag <= d_alloc ? mem_response : d_pend_tag;
			end
			else if (fill_done)
			begin
				await_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		for (int s = 0; s < `ICACHE_SETS; s++)
		begin
			for (int w = 0; w < `ICACHE_WAYS; w++)
			begin
				if (resp_hit[s][w])
				begin
					data_q[s][w] <= mem_resp.block;
				end
			end
		end
		if (d_alloc)
		begin
			tag_q[demand.index][d_victim] <= demand.tag;
		end
		if (p_alloc)
		begin
			tag_q[prefetch.index][p_victim] <= prefetch.tag;
		end
	end

	// every return belongs to a way that requested it
	a_resp_known: assert property (@(posedge clock) disable iff (reset)
		resp_live |-> resp_known);

	// memory takes every request in the cycle it is made
	a_req_tagged: assert property (@(posedge clock) disable iff (reset)
		mem_req.valid |-> mem_response != '0);

endmodule

//--- mem_model.sv
`include "icache_cfg.svh"

module mem_model (
	input logic clock,
	input logic reset,
	input mem_bus_pkg::mem_req_t mem_req,
	output mem_bus_pkg::mem_tag_t mem_response,
	output mem_bus_pkg::mem_resp_t mem_resp
);

	mem_bus_pkg::mem_tag_t next_tag;
	mem_bus_pkg::mem_tag_t pipe_tag [`MEM_LATENCY];
	mem_bus_pkg::mem_addr_t pipe_addr [`MEM_LATENCY];
	mem_bus_pkg::mem_addr_t out_addr;
	logic tag_clash;

	// tag handed out in the request cycle
	assign mem_response = mem_req.valid ? next_tag : '0;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			next_tag <= mem_bus_pkg::mem_tag_t'(1);
		end
		else if (mem_req.valid)
		begin
			// 1 to 15, zero stays free for idle
			next_tag <= (next_tag == '1) ? mem_bus_pkg::mem_tag_t'(1) : next_tag + 1'b1;
		end
	end

	// tag stage per cycle of latency, zero for an empty slot
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < `MEM_LATENCY; i++)
			begin
				pipe_tag[i] <= '0;
			end
		end
		else
		begin
			pipe_tag[0] <= mem_response;
			for (int i = 1; i < `MEM_LATENCY; i++)
			begin
				pipe_tag[i] <= pipe_tag[i-1];
			end
		end
	end

	always_ff @(posedge clock)
	begin
		pipe_addr[0] <= mem_req.addr;
		for (int i = 1; i < `MEM_LATENCY; i++)
		begin
			pipe_addr[i] <= pipe_addr[i-1];
		end
	end

	assign out_addr = pipe_addr[`MEM_LATENCY-1];

	// block contents follow from the line address
	assign mem_resp = '{
		tag: pipe_tag[`MEM_LATENCY-1],
		block: {out_addr, ~out_addr, out_addr ^ 16'hA5A5, out_addr + 16'd1}
	};

	always_comb
	begin
		tag_clash = 1'b0;
		for (int i = 0; i < `MEM_LATENCY; i++)
		begin
			for (int j = i + 1; j < `MEM_LATENCY; j++)
			begin
				if (pipe_tag[i] != '0 && pipe_tag[i] == pipe_tag[j])
				begin
					tag_clash = 1'b1;
				end
			end
		end
	end

	// counter must not wrap onto a tag still in flight
	a_unique_tags: assert property (@(posedge clock) disable iff (reset) !tag_clash);

endmodule

//--- icache_top.sv
module icache_top (
	input logic clock,
	input logic reset,
	input logic redirect_valid,
	input icache_pkg::pc_t redirect_pc,
	output icache_pkg::fetch_out_t fetch
);

	icache_pkg::lookup_t demand;
	icache_pkg::lookup_t prefetch;
	logic do_lookup;
	logic demand_hit;
	logic demand_miss;
	logic pref_miss;
	logic cache_full;
	logic fill_done;
	logic fetch_fire;
	logic cancel;
	icache_pkg::pc_t fetch_pc;
	icache_pkg::block_t read_data;
	mem_bus_pkg::mem_req_t mem_req;
	mem_bus_pkg::mem_tag_t mem_response;
	mem_bus_pkg::mem_resp_t mem_resp;

	// a redirect drops the awaited line
	assign cancel = redirect_valid;

	assign fetch = '{valid: fetch_fire, pc: fetch_pc, block: read_data};

	icache_ctrl u_ctrl (
		.clock(clock),
		.reset(reset),
		.redirect_valid(redirect_valid),
		.redirect_pc(redirect_pc),
		.demand_hit(demand_hit),
		.demand_miss(demand_miss),
		.pref_miss(pref_miss),
		.cache_full(cache_full),
		.fill_done(fill_done),
		.demand(demand),
		.prefetch(prefetch),
		.do_lookup(do_lookup),
		.fetch_pc(fetch_pc),
		.fetch_fire(fetch_fire)
	);

	icache_mem u_mem (
		.clock(clock),
		.reset(reset),
		.demand(demand),
		.prefetch(prefetch),
		.do_lookup(do_lookup),
		.cancel(cancel),
		.mem_response(mem_response),
		.mem_resp(mem_resp),
		.demand_hit(demand_hit),
		.demand_miss(demand_miss),
		.pref_miss(pref_miss),
		.cache_full(cache_full),
		.fill_done(fill_done),
		.read_data(read_data),
		.mem_req(mem_req)
	);

	mem_model u_memory (
		.clock(clock),
		.reset(reset),
		.mem_req(mem_req),
		.mem_response(mem_response),
		.mem_resp(mem_resp)
	);

endmodule

//--- icache_tb.sv
`include "icache_cfg.svh"

module icache_tb;

	localparam int EVICT_REDIRECTS = 3;
	localparam int LOOP_REDIRECTS = 6;
	localparam int RANDOM_REDIRECTS = 60;
	localparam int REDIRECT_COUNT = EVICT_REDIRECTS + LOOP_REDIRECTS + RANDOM_REDIRECTS;
	localparam int TIMEOUT_CYCLES = 40 * REDIRECT_COUNT + 200;
	localparam icache_pkg::pc_t STEP = 16'd8;
	localparam icache_pkg::pc_t LOOP_BASE = 16'h00c0;

	// model view of one set
	// an unknown entry may hold any line
	typedef struct packed
	{
		logic mru_known;
		icache_pkg::pc_t mru;
		logic lru_known;
		icache_pkg::pc_t lru;
	} model_set_t;

	logic clock;
	logic reset;
	logic redirect_valid;
	icache_pkg::pc_t redirect_pc;
	icache_pkg::fetch_out_t fetch;

	int cycle_count = 0;
	int ready_cycle;
	icache_pkg::pc_t expected_pc;
	icache_pkg::pc_t cancelled_pc;
	logic after_redirect;
	logic first_pending;
	logic redirect_q = 1'b0;
	logic reset_q = 1'b0;
	logic expect_hit;
	model_set_t model_sets [`ICACHE_SETS];

	icache_top UUT (
		.clock(clock),
		.reset(reset),
		.redirect_valid(redirect_valid),
		.redirect_pc(redirect_pc),
		.fetch(fetch)
	);

	function automatic icache_pkg::index_t set_of(input icache_pkg::pc_t addr);
		return addr[`ICACHE_OFFSET_SIZE +: `ICACHE_INDEX_SIZE];
	endfunction

	// memory contents for one line address
	function automatic icache_pkg::block_t expected_block(input icache_pkg::pc_t addr);
		return {addr, ~addr, addr ^ 16'hA5A5, addr + 16'd1};
	endfunction

	function automatic logic holds_line(input model_set_t s, input icache_pkg::pc_t line);
		return (s.mru_known && s.mru == line) || (s.lru_known && s.lru == line);
	endfunction

	// hit or forward makes the line most recent
	function automatic model_set_t touch_line(input model_set_t s, input icache_pkg::pc_t line);
		model_set_t n;
		n.mru_known = 1'b1;
		n.mru = line;
		if (s.mru_known && s.mru == line)
		begin
			n.lru_known = s.lru_known;
			n.lru = s.lru;
		end
		else
		begin
			n.lru_known = s.mru_known;
			n.lru = s.mru;
		end
		return n;
	endfunction

	// filled line with an unknown LRU position
	function automatic model_set_t park_line(input icache_pkg::pc_t line);
		model_set_t n;
		n.mru_known = 1'b0;
		n.mru = '0;
		n.lru_known = 1'b1;
		n.lru = line;
		return n;
	endfunction

	// a line not in the model may evict the oldest known entry
	function automatic model_set_t allow_fill(input model_set_t s, input icache_pkg::pc_t line);
		model_set_t n;
		if (holds_line(s, line))
		begin
			n = s;
		end
		else
		begin
			n.mru_known = 1'b0;
			n.mru = '0;
			n.lru_known = s.mru_known;
			n.lru = s.mru;
		end
		return n;
	endfunction

	task automatic stop_run();
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic report_mismatch(input string test_name, input logic [63:0] expected_value,
		input logic [63:0] actual_value);
		$display("Fail %s expected %h actual %h", test_name, expected_value, actual_value);
		stop_run();
	endtask

	task automatic redirect_to(input icache_pkg::pc_t target);
		@(posedge clock);
		redirect_valid <= 1'b1;
		redirect_pc <= target;
		@(posedge clock);
		redirect_valid <= 1'b0;
	endtask

	task automatic wait_for_fetch(input icache_pkg::pc_t target);
		do
		begin
			@(negedge clock);
		end
		while (!(fetch.valid && fetch.pc == target));
	endtask

	initial
	begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	assign expect_hit = holds_line(model_sets[set_of(fetch.pc)], fetch.pc);

	// reference model of next pc, ready cycle and known lines per set
	always @(posedge clock)
	begin : model_update
		icache_pkg::pc_t next_line;
		icache_pkg::pc_t far_line;
		next_line = fetch.pc + STEP;
		far_line = fetch.pc + STEP + STEP;
		cycle_count <= cycle_count + 1;
		reset_q <= reset;
		redirect_q <= redirect_valid;
		if (reset)
		begin
			for (int s = 0; s < `ICACHE_SETS; s++)
			begin
				model_sets[s] <= '0;
			end
			expected_pc <= '0;
			cancelled_pc <= '0;
			ready_cycle <= cycle_count + 1;
			after_redirect <= 1'b0;
			first_pending <= 1'b1;
		end
		else if (redirect_valid)
		begin
			expected_pc <= redirect_pc;
			cancelled_pc <= expected_pc;
			after_redirect <= 1'b1;
			// one cycle in REDIRECT before the lookup
			ready_cycle <= cycle_count + 2;
			model_sets[set_of(expected_pc)] <=
				allow_fill(model_sets[set_of(expected_pc)], expected_pc);
		end
		else if (fetch.valid)
		begin
			expected_pc <= next_line;
			ready_cycle <= cycle_count + 1;
			after_redirect <= 1'b0;
			first_pending <= 1'b0;
			if (cycle_count == ready_cycle)
			begin
				model_sets[set_of(fetch.pc)] <= touch_line(model_sets[set_of(fetch.pc)], fetch.pc);
			end
			else
			begin
				model_sets[set_of(fetch.pc)] <= park_line(fetch.pc);
			end
			// prefetch pointer sits one or two lines ahead
			model_sets[set_of(next_line)] <= allow_fill(model_sets[set_of(next_line)], next_line);
			model_sets[set_of(far_line)] <= allow_fill(model_sets[set_of(far_line)], far_line);
		end
	end

	order_check: assert property (@(posedge clock) disable iff (reset)
		fetch.valid |-> fetch.pc == expected_pc)
		else report_mismatch("order", $sampled(expected_pc), $sampled(fetch.pc));

	data_check: assert property (@(posedge clock) disable iff (reset)
		fetch.valid |-> fetch.block == expected_block(fetch.pc))
		else report_mismatch("data", expected_block($sampled(fetch.pc)), $sampled(fetch.block));

	hit_latency_check: assert property (@(posedge clock) disable iff (reset)
		fetch.valid && expect_hit |-> cycle_count == ready_cycle)
		else report_mismatch("hit_latency", $sampled(ready_cycle), $sampled(cycle_count));

	redirect_quiet_check: assert property (@(posedge clock) disable iff (reset)
		redirect_valid || redirect_q |-> !fetch.valid)
		else report_mismatch("redirect_quiet", 64'd0, $sampled(fetch.valid));

	cancel_check: assert property (@(posedge clock) disable iff (reset)
		fetch.valid && after_redirect && cancelled_pc != expected_pc |-> fetch.pc != cancelled_pc)
		else report_mismatch("redirect_cancel", $sampled(expected_pc), $sampled(fetch.pc));

	reset_quiet_check: assert property (@(posedge clock)
		reset_q |-> !fetch.valid)
		else report_mismatch("reset_quiet", 64'd0, $sampled(fetch.valid));

	first_pc_check: assert property (@(posedge clock) disable iff (reset)
		fetch.valid && first_pending |-> fetch.pc == '0)
		else report_mismatch("first_pc", 64'd0, $sampled(fetch.pc));

	initial
	begin
		wait (cycle_count >= TIMEOUT_CYCLES);
		$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		stop_run();
	end

	initial
	begin
		int unsigned gap;
		icache_pkg::pc_t target;
		void'($urandom(6747));
		reset = 1'b1;
		redirect_valid = 1'b0;
		redirect_pc = '0;
		target = '0;
		repeat (3) @(posedge clock);
		reset <= 1'b0;
		wait_for_fetch(16'h0000);

		// three lines in set 0 and back to the oldest
		redirect_to(16'h0080);
		wait_for_fetch(16'h0080);
		redirect_to(16'h0100);
		wait_for_fetch(16'h0100);
		redirect_to(16'h0000);
		wait_for_fetch(16'h0000);

		// four line loop that hits from the second pass on
		for (int i = 0; i < LOOP_REDIRECTS; i++)
		begin
			redirect_to(LOOP_BASE);
			wait_for_fetch(LOOP_BASE + 16'd24);
		end

		for (int i = 0; i < RANDOM_REDIRECTS; i++)
		begin
			gap = $urandom % 30;
			if ($urandom % 4 == 0)
			begin
				target = LOOP_BASE;
			end
			else
			begin
				target = icache_pkg::pc_t'(($urandom % 32) * 8);
			end
			repeat (gap) @(posedge clock);
			redirect_to(target);
		end
		wait_for_fetch(target);
		// late returns of cancelled lines drain
		repeat (2 * `MEM_LATENCY) @(posedge clock);
		$display("STATUS: PASS");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+.
icache_pkg.sv
mem_bus_pkg.sv
icache_ctrl.sv
icache_mem.sv
mem_model.sv
icache_top.sv
icache_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert -j 0
TOP = icache_tb
FILELIST = verilog.f
OBJ_DIR = obj_dir
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

# the log decides the result, the simulator status is not used
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then echo "test failed, no result in log"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
